/* common/boot_pkg.sv */
package boot_pkg;

   // datapath
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // on-chip sram
   localparam int SRAM_WORDS = 64;
   localparam int SRAM_AW = 6;

   // boot image
   localparam int ROM_WORDS = 16;
   localparam int ROM_AW = 4;

   // boot code lands in the top words of the sram
   localparam int BOOT_BASE = SRAM_WORDS - ROM_WORDS;

   // software requested cpu reset
   localparam int RST_PULSE_CYCLES = 12;
   localparam int PULSE_CNT_W = $clog2(RST_PULSE_CYCLES + 1);

   // control register write data: bit 0 boot flag, bit 1 reset request
   localparam int CTRL_WDATA_W = 2;

   typedef logic [DATA_W-1:0]       data_t;
   typedef logic [STRB_W-1:0]       strb_t;
   typedef logic [SRAM_AW-1:0]      sram_addr_t;
   typedef logic [ROM_AW-1:0]       rom_addr_t;
   typedef logic [PULSE_CNT_W-1:0]  pulse_cnt_t;
   typedef logic [CTRL_WDATA_W-1:0] ctrl_wdata_t;

   typedef struct packed {
      logic        valid;
      ctrl_wdata_t wdata;
      strb_t       wstrb;
   } ctrl_req_t;

   typedef struct packed {
      logic  ready;
      logic  rvalid;
      data_t rdata;
   } ctrl_rsp_t;

   // cpu data port, no strobes means read
   typedef struct packed {
      logic       valid;
      sram_addr_t addr;
      data_t      wdata;
      strb_t      wstrb;
   } mem_req_t;

   typedef struct packed {
      logic  ready;
      logic  rvalid;
      data_t rdata;
   } mem_rsp_t;

   // loader always writes full words
   typedef struct packed {
      logic       valid;
      sram_addr_t addr;
      data_t      wdata;
   } load_wr_t;

   typedef enum logic [1:0] {
      COPY_READ,
      COPY_LAST,
      COPY_DONE
   } copy_state_t;

endpackage

/* boot_ctrl/boot_rom.sv */
`timescale 1ns/10ps

module boot_rom (
   input  logic                clk_i,
   input  logic                rd_en_i,
   input  boot_pkg::rom_addr_t addr_i,
   output boot_pkg::data_t     rdata_o
);

   boot_pkg::data_t mem [boot_pkg::ROM_WORDS];
   boot_pkg::data_t rdata_q;

   // image file sits next to the simulation run directory
   initial begin
      $readmemh("boot.hex", mem);
   end

   // output holds its value between enabled reads
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rdata_q <= mem[addr_i];
      end
   end

   assign rdata_o = rdata_q;

endmodule

/* boot_ctrl/reset_pulse_gen.sv */
`timescale 1ns/10ps

module reset_pulse_gen (
   input  logic clk_i,
   input  logic arst_i,
   input  logic start_i,
   output logic pulse_o
);

   boot_pkg::pulse_cnt_t cnt_q;

   // start reloads even while a pulse is running
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         cnt_q <= '0;
      end else if (start_i) begin
         cnt_q <= boot_pkg::pulse_cnt_t'(boot_pkg::RST_PULSE_CYCLES);
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // high for exactly RST_PULSE_CYCLES cycles after the start
   assign pulse_o = (cnt_q != '0);

endmodule

/* boot_ctrl/boot_ctrl.sv */
`timescale 1ns/10ps

module boot_ctrl (
   input  logic                clk_i,
   input  logic                arst_i,
   input  boot_pkg::ctrl_req_t ctrl_req_i,
   output boot_pkg::ctrl_rsp_t ctrl_rsp_o,
   output boot_pkg::load_wr_t  load_wr_o,
   output logic                cpu_rst_o,
   output logic                boot_o
);

   logic boot_wr;
   logic boot_rd;
   logic boot_nxt;
   logic boot_q;
   logic rvalid_q;
   logic rst_req;
   logic rst_pulse;
   logic loading;

   boot_pkg::copy_state_t state_q;
   boot_pkg::rom_addr_t   rom_addr_q;
   logic                  rom_rd_en;
   boot_pkg::data_t       rom_rdata;
   logic                  wr_valid_q;
   boot_pkg::sram_addr_t  wr_addr_q;

   // control register access
   assign boot_wr = ctrl_req_i.valid & (|ctrl_req_i.wstrb);
   assign boot_rd = ctrl_req_i.valid & ~(|ctrl_req_i.wstrb);
   assign rst_req = boot_wr & ctrl_req_i.wdata[1];

   // value the boot flag takes at the next edge
   assign boot_nxt = boot_wr ? ctrl_req_i.wdata[0] : boot_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         boot_q   <= 1'b1;
         rvalid_q <= 1'b0;
      end else begin
         boot_q   <= boot_nxt;
         rvalid_q <= boot_rd;
      end
   end

   assign ctrl_rsp_o.ready  = 1'b1;
   assign ctrl_rsp_o.rvalid = rvalid_q;
   assign ctrl_rsp_o.rdata  = {{(boot_pkg::DATA_W-1){1'b0}}, boot_q};
   assign boot_o            = boot_q;

   // copy sequencer, rom read in cycle k, sram write in cycle k+1
   assign rom_rd_en = (state_q == boot_pkg::COPY_READ) & boot_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q    <= boot_pkg::COPY_READ;
         rom_addr_q <= '0;
         wr_valid_q <= 1'b0;
      end else begin
         // drop the pending write if software clears the flag
         wr_valid_q <= rom_rd_en & boot_nxt;
         case (state_q)
            boot_pkg::COPY_READ: begin
               if (!boot_q) begin
                  state_q <= boot_pkg::COPY_DONE;
               end else begin
                  rom_addr_q <= rom_addr_q + 1'b1;
                  if (rom_addr_q == boot_pkg::rom_addr_t'(boot_pkg::ROM_WORDS - 1)) begin
                     state_q <= boot_pkg::COPY_LAST;
                  end
               end
            end
            boot_pkg::COPY_LAST: begin
               state_q <= boot_pkg::COPY_DONE;
            end
            default: begin
               state_q <= boot_pkg::COPY_DONE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      wr_addr_q <= boot_pkg::sram_addr_t'(boot_pkg::BOOT_BASE + rom_addr_q);
   end

   assign load_wr_o.valid = wr_valid_q;
   assign load_wr_o.addr  = wr_addr_q;
   assign load_wr_o.wdata = rom_rdata;

   // cpu held in reset while loading or on request
   assign loading   = (state_q != boot_pkg::COPY_DONE) | wr_valid_q;
   assign cpu_rst_o = loading | rst_pulse;

   boot_rom i_boot_rom (
      .clk_i   (clk_i),
      .rd_en_i (rom_rd_en),
      .addr_i  (rom_addr_q),
      .rdata_o (rom_rdata)
   );

   reset_pulse_gen i_reset_pulse_gen (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .start_i (rst_req),
      .pulse_o (rst_pulse)
   );

   a_load_needs_boot: assert property (
      @(posedge clk_i) disable iff (arst_i)
      load_wr_o.valid |-> boot_o
   ) else $error("loader write while boot flag is clear");

   a_load_in_region: assert property (
      @(posedge clk_i) disable iff (arst_i)
      load_wr_o.valid |-> (load_wr_o.addr >= boot_pkg::sram_addr_t'(boot_pkg::BOOT_BASE))
   ) else $error("loader write outside boot region");

endmodule

/* source/boot_sram.sv */
`timescale 1ns/10ps

module boot_sram (
   input  logic               clk_i,
   input  logic               arst_i,
   input  boot_pkg::load_wr_t load_wr_i,
   input  boot_pkg::mem_req_t mem_req_i,
   output boot_pkg::mem_rsp_t mem_rsp_o
);

   boot_pkg::data_t mem [boot_pkg::SRAM_WORDS];
   boot_pkg::data_t rdata_q;
   logic            rvalid_q;
   logic            cpu_ready;
   logic            cpu_acc;
   logic            cpu_wr;
   logic            cpu_rd;

   // loader owns the port whenever it writes
   assign cpu_ready = ~load_wr_i.valid;
   assign cpu_acc   = mem_req_i.valid & cpu_ready;
   assign cpu_wr    = cpu_acc & (|mem_req_i.wstrb);
   assign cpu_rd    = cpu_acc & ~(|mem_req_i.wstrb);

   always_ff @(posedge clk_i) begin
      if (load_wr_i.valid) begin
         mem[load_wr_i.addr] <= load_wr_i.wdata;
      end else if (cpu_wr) begin
         for (int b = 0; b < boot_pkg::STRB_W; b++) begin
            if (mem_req_i.wstrb[b]) begin
               mem[mem_req_i.addr][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
            end
         end
      end
      if (cpu_rd) begin
         rdata_q <= mem[mem_req_i.addr];
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= cpu_rd;
      end
   end

   assign mem_rsp_o.ready  = cpu_ready;
   assign mem_rsp_o.rvalid = rvalid_q;
   assign mem_rsp_o.rdata  = rdata_q;

   // read data never comes from a cycle the loader owned
   a_no_rd_during_load: assert property (
      @(posedge clk_i) disable iff (arst_i)
      mem_rsp_o.rvalid |-> $past(!load_wr_i.valid)
   ) else $error("cpu read accepted during loader write");

endmodule

/* source/boot_subsys_top.sv */
`timescale 1ns/10ps

module boot_subsys_top (
   input  logic                clk_i,
   input  logic                arst_i,
   input  boot_pkg::ctrl_req_t ctrl_req_i,
   output boot_pkg::ctrl_rsp_t ctrl_rsp_o,
   input  boot_pkg::mem_req_t  mem_req_i,
   output boot_pkg::mem_rsp_t  mem_rsp_o,
   output logic                cpu_rst_o,
   output logic                boot_o
);

   // loader path from the controller into the sram
   boot_pkg::load_wr_t load_wr;

   boot_ctrl i_boot_ctrl (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .ctrl_req_i (ctrl_req_i),
      .ctrl_rsp_o (ctrl_rsp_o),
      .load_wr_o  (load_wr),
      .cpu_rst_o  (cpu_rst_o),
      .boot_o     (boot_o)
   );

   // cpu data port shares the single sram port with the loader
   boot_sram i_boot_sram (
      .clk_i     (clk_i),
      .arst_i    (arst_i),
      .load_wr_i (load_wr),
      .mem_req_i (mem_req_i),
      .mem_rsp_o (mem_rsp_o)
   );

endmodule

/* tb/boot_subsys_tb.sv */
`timescale 1ns/10ps

module boot_subsys_tb;

   localparam int TIMEOUT_CYCLES = 64;
   localparam int LFSR_SEED = 1723;

   logic                clk;
   logic                arst;
   boot_pkg::ctrl_req_t ctrl_req;
   boot_pkg::ctrl_rsp_t ctrl_rsp;
   boot_pkg::mem_req_t  mem_req;
   boot_pkg::mem_rsp_t  mem_rsp;
   logic                cpu_rst;
   logic                boot;

   boot_pkg::data_t image [boot_pkg::ROM_WORDS];
   boot_pkg::data_t model [boot_pkg::SRAM_WORDS];
   boot_pkg::strb_t known [boot_pkg::SRAM_WORDS];

   int          errors;
   int          timeouts;
   logic [31:0] lfsr;

   boot_subsys_top i_dut (
      .clk_i      (clk),
      .arst_i     (arst),
      .ctrl_req_i (ctrl_req),
      .ctrl_rsp_o (ctrl_rsp),
      .mem_req_i  (mem_req),
      .mem_rsp_o  (mem_rsp),
      .cpu_rst_o  (cpu_rst),
      .boot_o     (boot)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h80200003;
      end
      return n;
   endfunction

   // one lfsr step per bit
   function automatic boot_pkg::data_t random_word();
      boot_pkg::data_t w;
      for (int i = 0; i < boot_pkg::DATA_W; i++) begin
         lfsr = lfsr_next(lfsr);
         w[i] = lfsr[0];
      end
      return w;
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      if (actual !== expected) begin
         errors++;
         $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic report_timeout(input string what);
      timeouts++;
      $display("timeout at %0t ns: %s did not arrive", $time, what);
   endtask

   task automatic wait_ready(input bit on_ctrl, input string what, output bit ok);
      int n;
      n = 0;
      while (!(on_ctrl ? ctrl_rsp.ready : mem_rsp.ready) && n < TIMEOUT_CYCLES) begin
         @(negedge clk);
         n++;
      end
      ok = on_ctrl ? ctrl_rsp.ready : mem_rsp.ready;
      if (!ok) begin
         report_timeout({"ready for ", what});
      end
   endtask

   // cycles from acceptance to rvalid, 0 when it never came
   task automatic wait_rvalid(input bit on_ctrl, input string what, output int lat);
      int n;
      n = 1;
      while (!(on_ctrl ? ctrl_rsp.rvalid : mem_rsp.rvalid) && n < TIMEOUT_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (on_ctrl ? ctrl_rsp.rvalid : mem_rsp.rvalid) begin
         lat = n;
      end else begin
         lat = 0;
         report_timeout({"rvalid for ", what});
      end
   endtask

   task automatic ctrl_write(input logic [1:0] wdata);
      bit ok;
      ctrl_req.valid = 1'b1;
      ctrl_req.wdata = wdata;
      ctrl_req.wstrb = '1;
      wait_ready(1'b1, "control write", ok);
      @(negedge clk);
      ctrl_req = '0;
      if (ok) begin
         check(32'(boot), 32'(wdata[0]), "boot flag after control write");
      end
   endtask

   task automatic ctrl_read(input logic flag);
      bit ok;
      int lat;
      ctrl_req.valid = 1'b1;
      ctrl_req.wdata = '0;
      ctrl_req.wstrb = '0;
      wait_ready(1'b1, "control read", ok);
      @(negedge clk);
      ctrl_req = '0;
      if (ok) begin
         wait_rvalid(1'b1, "control read", lat);
         if (lat != 0) begin
            check(32'(lat), 32'd1, "control read latency");
            check(ctrl_rsp.rdata, 32'(flag), "control read data");
         end
      end
   endtask

   task automatic mem_write(input boot_pkg::sram_addr_t addr, input boot_pkg::data_t data,
                            input boot_pkg::strb_t strb);
      bit ok;
      mem_req.valid = 1'b1;
      mem_req.addr  = addr;
      mem_req.wdata = data;
      mem_req.wstrb = strb;
      wait_ready(1'b0, "sram write", ok);
      @(negedge clk);
      mem_req = '0;
      if (ok) begin
         // byte merge under the strobe
         for (int b = 0; b < boot_pkg::STRB_W; b++) begin
            if (strb[b]) begin
               model[addr][8*b +: 8] = data[8*b +: 8];
               known[addr][b] = 1'b1;
            end
         end
      end
   endtask

   task automatic mem_read(input boot_pkg::sram_addr_t addr);
      bit ok;
      int lat;
      if (known[addr] != '1) begin
         errors++;
         $display("test file reads sram word %h, which holds bytes never written", addr);
         return;
      end
      mem_req.valid = 1'b1;
      mem_req.addr  = addr;
      mem_req.wdata = '0;
      mem_req.wstrb = '0;
      wait_ready(1'b0, "sram read", ok);
      @(negedge clk);
      mem_req = '0;
      if (ok) begin
         wait_rvalid(1'b0, "sram read", lat);
         if (lat != 0) begin
            check(32'(lat), 32'd1, "sram read latency");
            check(mem_rsp.rdata, model[addr], $sformatf("sram word %h", addr));
         end
      end
   endtask

   task automatic measure_pulse(input int expected);
      int n;
      int len;
      n = 0;
      while (!cpu_rst && n < TIMEOUT_CYCLES) begin
         @(negedge clk);
         n++;
      end
      if (!cpu_rst) begin
         report_timeout("rising edge of the cpu reset pulse");
         return;
      end
      len = 0;
      while (cpu_rst && len < TIMEOUT_CYCLES) begin
         // no second copy, so the cpu port stays free
         check(32'(mem_rsp.ready), 32'd1, "cpu port ready during reset pulse");
         len++;
         @(negedge clk);
      end
      if (cpu_rst) begin
         report_timeout("falling edge of the cpu reset pulse");
      end else begin
         check(32'(len), 32'(expected), "reset pulse length");
      end
   endtask

   task automatic power_up();
      int n;
      repeat (5) @(negedge clk);
      check(32'(boot), 32'd1, "boot flag in reset");
      check(32'(cpu_rst), 32'd1, "cpu reset in reset");
      arst = 1'b0;
      // release cycle is the first loading cycle
      n = 1;
      @(negedge clk);
      while (cpu_rst && n < TIMEOUT_CYCLES) begin
         check(32'(mem_rsp.ready), 32'd0, "cpu port ready while loading");
         n++;
         @(negedge clk);
      end
      if (cpu_rst) begin
         report_timeout("end of the boot image copy");
      end else begin
         check(32'(n), 32'(boot_pkg::ROM_WORDS + 1), "cpu reset cycles after release");
      end
      check(32'(boot), 32'd1, "boot flag after copy");
   endtask

   task automatic run_tests();
      int          fd;
      int          cnt;
      string       line;
      byte         op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] s;
      fd = $fopen("tb/boot_tests.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the test file tb/boot_tests.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         cnt = $fgets(line, fd);
         if (cnt > 0) begin
            op = line.getc(0);
            case (op)
               "C": begin
                  cnt = $sscanf(line, "C %h", d);
                  ctrl_write(d[1:0]);
               end
               "Q": begin
                  cnt = $sscanf(line, "Q %h", d);
                  ctrl_read(d[0]);
               end
               "W": begin
                  cnt = $sscanf(line, "W %h %h %h", a, d, s);
                  if (cnt != 3) begin
                     cnt = $sscanf(line, "W %h R %h", a, s);
                     d = random_word();
                  end
                  mem_write(boot_pkg::sram_addr_t'(a), d, boot_pkg::strb_t'(s));
               end
               "M": begin
                  cnt = $sscanf(line, "M %h", a);
                  mem_read(boot_pkg::sram_addr_t'(a));
               end
               "P": begin
                  cnt = $sscanf(line, "P %h", d);
                  measure_pulse(int'(d));
               end
               "#", "\n", " ": begin
               end
               default: begin
                  errors++;
                  $display("test file holds an unknown command: %s", line);
               end
            endcase
         end
      end
      $fclose(fd);
   endtask

   initial begin
      errors   = 0;
      timeouts = 0;
      lfsr     = 32'(LFSR_SEED);
      arst     = 1'b1;
      ctrl_req = '0;
      mem_req  = '0;
      $readmemh("source/boot.hex", image);
      for (int i = 0; i < boot_pkg::SRAM_WORDS; i++) begin
         model[i] = '0;
         known[i] = '0;
      end
      // boot region holds the image once the copy is done
      for (int k = 0; k < boot_pkg::ROM_WORDS; k++) begin
         model[boot_pkg::BOOT_BASE + k] = image[k];
         known[boot_pkg::BOOT_BASE + k] = '1;
      end
      power_up();
      run_tests();
      $display("errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* source/boot.hex */
// one 32-bit boot word per line, rom address 0 upward
00000297
03028293
00100313
0062a023
00428293
fff30313
fe031ce3
000012b7
80028293
00028067
0000006f
13579bdf
2468ace0
deadbeef
0f1e2d3c
a5c3e781

/* tb/boot_tests.txt */
# one command per line, all fields hex
# C wdata | Q flag | W addr data-or-R strb | M addr | P pulse cycles
M 30
M 31
M 32
M 33
M 34
M 35
M 36
M 37
M 38
M 39
M 3a
M 3b
M 3c
M 3d
M 3e
M 3f
W 05 R f
W 05 a5a5a5a5 5
M 05
W 12 R f
W 12 0000beef 3
M 12
W 33 R 6
M 33
C 0
Q 0
C 1
Q 1
C 3
P c
M 33
M 30

/* boot_subsys_top.f */
common/boot_pkg.sv
boot_ctrl/boot_rom.sv
boot_ctrl/reset_pulse_gen.sv
boot_ctrl/boot_ctrl.sv
source/boot_sram.sv
source/boot_subsys_top.sv
tb/boot_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1
# the boot rom loads boot.hex from the run directory
cp source/boot.hex boot.hex &&
verilator --binary --timing --assert -Wno-fatal --top-module boot_subsys_tb \
   -f boot_subsys_top.f -o boot_subsys_sim > build.log 2>&1 &&
./obj_dir/boot_subsys_sim > sim.log 2>&1 ||
   { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" ||
   { echo "simulation failed, see sim.log"; exit 1; }
